// ==== tb.f ====
+incdir+source
source/board_pkg.sv
source/ui_pkg.sv
source/scan_decoder.sv
source/turn_control.sv
source/move_engine.sv
source/score_display.sv
source/checkers_top.sv
test/tb_checkers.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_checkers
FLIST     ?= tb.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run and look for the pass message"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "Variables: VERILATOR TOP FLIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$($(BUILD_DIR)/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_checkers.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "checkers_macros.svh"

module tb_checkers;
  import board_pkg::*;
  import ui_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_KEYS  = 400;
  localparam int NUM_STROBES  = 200 + RANDOM_KEYS;  // Directed tests stay below 200 keys
  localparam int WATCHDOG_NS  = (NUM_STROBES * 4 + RESET_CYCLES) * CLK_PERIOD * 3 / 2;

  logic       clk = 1'b0;
  logic       resetn;
  scan_code_e scan_code;
  logic       scan_valid;
  board_t     board;
  player_e    turn;
  coord_t     cursor_x, cursor_y, sel_x, sel_y;
  logic       show_highlight;
  seg_t       hex0, hex1, hex4, hex5;

  // Reference model of the game
  board_t      m_board;
  player_e     m_turn;
  score_t      m_red_score, m_black_score;
  coord_t      m_cx, m_cy, m_sx, m_sy;
  turn_state_e m_state;
  logic        m_brk;  // F0 prefix pending

  logic [31:0] rng;
  int          err_board, err_coord, err_player, err_seg, err_flag;

  always #(CLK_PERIOD / 2) clk = ~clk;

  checkers_top checkers_top_i (
    .clk            (clk),
    .resetn         (resetn),
    .scan_code      (scan_code),
    .scan_valid     (scan_valid),
    .board          (board),
    .turn           (turn),
    .cursor_x       (cursor_x),
    .cursor_y       (cursor_y),
    .sel_x          (sel_x),
    .sel_y          (sel_y),
    .show_highlight (show_highlight),
    .hex0           (hex0),
    .hex1           (hex1),
    .hex4           (hex4),
    .hex5           (hex5)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int iabs(input int v);
    return (v < 0) ? -v : v;
  endfunction

  // Men on squares with x+y even, red rows 0..2, black rows 5..7
  function automatic board_t start_position();
    board_t b;
    for (int y = 0; y < `CK_BOARD_DIM; y++) begin
      for (int x = 0; x < `CK_BOARD_DIM; x++) begin
        b[y][x] = empty;
        if ((x + y) % 2 == 0 && y < 3) b[y][x] = red_man;
        if ((x + y) % 2 == 0 && y > 4) b[y][x] = black_man;
      end
    end
    return b;
  endfunction

  // Table kept in a..g order, reversed into seg_t where bit 0 is a
  function automatic seg_t expected_digit(input int d);
    logic [6:0] a_to_g;
    seg_t       s;
    case (d)
      0:       a_to_g = 7'b0000001;
      1:       a_to_g = 7'b1001111;
      2:       a_to_g = 7'b0010010;
      3:       a_to_g = 7'b0000110;
      4:       a_to_g = 7'b1001100;
      5:       a_to_g = 7'b0100100;
      6:       a_to_g = 7'b0100000;
      7:       a_to_g = 7'b0001111;
      8:       a_to_g = 7'b0000000;
      9:       a_to_g = 7'b0000100;
      default: a_to_g = 7'b1111111;
    endcase
    for (int i = 0; i < 7; i++) s[i] = a_to_g[6 - i];
    return s;
  endfunction

  task automatic check_board(input board_t exp, input board_t act, input string name);
    if (act !== exp) begin
      err_board++;
      $display("error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_coord(input coord_t exp, input coord_t act, input string name);
    if (act !== exp) begin
      err_coord++;
      $display("error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_player(input player_e exp, input player_e act, input string name);
    if (act !== exp) begin
      err_player++;
      $display("error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_seg(input seg_t exp, input seg_t act, input string name);
    if (act !== exp) begin
      err_seg++;
      $display("error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      err_flag++;
      $display("error: %s expected %h got %h", name, exp, act);
    end
  endtask

  task automatic model_move();
    int     dx, dy, mx, my;
    piece_e src, mid, placed;
    logic   own, opp, king, fwd, step, jump;
    dx   = int'(m_cx) - int'(m_sx);
    dy   = int'(m_cy) - int'(m_sy);
    mx   = (int'(m_sx) + int'(m_cx)) / 2;
    my   = (int'(m_sy) + int'(m_cy)) / 2;
    src  = m_board[m_sy][m_sx];
    mid  = m_board[my][mx];
    own  = (m_turn == red) ? (src == red_man || src == red_king)
                           : (src == black_man || src == black_king);
    opp  = (m_turn == red) ? (mid == black_man || mid == black_king)
                           : (mid == red_man || mid == red_king);
    king = (src == red_king || src == black_king);
    fwd  = (m_turn == red) ? (dy > 0) : (dy < 0);  // Red heads for row 7
    step = (iabs(dx) == 1 && iabs(dy) == 1);
    jump = (iabs(dx) == 2 && iabs(dy) == 2 && opp);
    if (own && m_board[m_cy][m_cx] == empty && (king || fwd) && (step || jump)) begin
      placed = src;
      if (src == red_man && m_cy == 3'd7) placed = red_king;
      if (src == black_man && m_cy == 3'd0) placed = black_king;
      m_board[m_sy][m_sx] = empty;
      if (jump) begin
        m_board[my][mx] = empty;
        if (m_turn == red) m_red_score = m_red_score + 4'd1;
        else m_black_score = m_black_score + 4'd1;
      end
      m_board[m_cy][m_cx] = placed;
      m_turn = (m_turn == red) ? black : red;
    end
  endtask

  task automatic model_key(input scan_code_e code);
    if (m_brk) begin
      m_brk = 1'b0;  // Released key
    end else begin
      case (code)
        key_break: m_brk = 1'b1;
        key_left:  m_cx = m_cx - 3'd1;
        key_right: m_cx = m_cx + 3'd1;
        key_up:    m_cy = m_cy - 3'd1;
        key_down:  m_cy = m_cy + 3'd1;
        key_space: begin
          case (m_state)
            start_screen: m_state = pick_piece;
            pick_piece: begin
              m_sx    = m_cx;
              m_sy    = m_cy;
              m_state = place_piece;
            end
            default: begin
              model_move();
              m_state = pick_piece;
            end
          endcase
        end
        default: ;
      endcase
    end
  endtask

  task automatic send_key(input scan_code_e code);
    @(posedge clk);
    scan_code  <= code;
    scan_valid <= 1'b1;
    @(posedge clk);
    scan_valid <= 1'b0;
    repeat (3) @(posedge clk);
    model_key(code);
  endtask

  // Sampled mid-cycle, away from the clock edge
  task automatic check_all();
    @(negedge clk);
    check_board(m_board, board, "board");
    check_player(m_turn, turn, "turn");
    check_coord(m_cx, cursor_x, "cursor_x");
    check_coord(m_cy, cursor_y, "cursor_y");
    check_coord(m_sx, sel_x, "sel_x");
    check_coord(m_sy, sel_y, "sel_y");
    check_flag(m_state == place_piece, show_highlight, "show_highlight");
    check_seg(expected_digit(int'(m_black_score) % 10), hex0, "hex0");
    check_seg(expected_digit(int'(m_black_score) / 10), hex1, "hex1");
    check_seg(expected_digit(int'(m_red_score) % 10), hex4, "hex4");
    check_seg(expected_digit(int'(m_red_score) / 10), hex5, "hex5");
  endtask

  task automatic goto_square(input coord_t x, input coord_t y);
    while (m_cx != x) send_key((m_cx < x) ? key_right : key_left);
    while (m_cy != y) send_key((m_cy < y) ? key_down : key_up);
  endtask

  task automatic try_move(input coord_t sx, input coord_t sy, input coord_t tx, input coord_t ty);
    goto_square(sx, sy);
    send_key(key_space);
    goto_square(tx, ty);
    send_key(key_space);
    check_all();
  endtask

  task automatic refused_move(input coord_t sx, input coord_t sy, input coord_t tx,
                              input coord_t ty, input string what);
    board_t  snap;
    player_e snap_turn;
    snap      = m_board;
    snap_turn = m_turn;
    try_move(sx, sy, tx, ty);
    check_board(snap, board, {"board after ", what});
    check_player(snap_turn, turn, {"turn after ", what});
  endtask

  task automatic after_reset();
    check_all();
    check_board(start_position(), board, "board after reset");
    check_player(red, turn, "turn after reset");
    check_flag(1'b0, show_highlight, "show_highlight after reset");
  endtask

  task automatic cursor_moves();
    send_key(key_left);
    check_all();
    check_coord(3'd7, cursor_x, "cursor_x wrap left");
    send_key(key_right);
    send_key(key_up);
    send_key(key_down);
    check_all();
    check_coord(3'd0, cursor_y, "cursor_y wrap down");
    send_key(key_break);
    send_key(key_right);  // Release code, no move
    check_all();
    check_coord(3'd0, cursor_x, "cursor_x after break");
  endtask

  task automatic selection_highlight();
    send_key(key_space);  // Leave start screen
    check_all();
    goto_square(3'd2, 3'd2);
    send_key(key_space);
    check_all();
    check_coord(3'd2, sel_x, "sel_x after select");
    check_flag(1'b1, show_highlight, "show_highlight after select");
    send_key(key_space);
    check_all();
    check_flag(1'b0, show_highlight, "show_highlight after place");
  endtask

  task automatic simple_moves();
    refused_move(3'd1, 3'd5, 3'd0, 3'd4, "opponent piece");
    try_move(3'd2, 3'd2, 3'd3, 3'd3);
    check_player(black, turn, "turn after red step");
    try_move(3'd1, 3'd5, 3'd2, 3'd4);
    refused_move(3'd3, 3'd3, 3'd2, 3'd2, "backward move");
    refused_move(3'd1, 3'd1, 3'd0, 3'd2, "occupied target");
    refused_move(3'd3, 3'd3, 3'd3, 3'd4, "straight move");
  endtask

  task automatic scripted_capture();
    try_move(3'd3, 3'd3, 3'd1, 3'd5);  // Over black at (2,4)
    check_flag(1'b1, board[4][2] == empty, "captured square empty");
    check_seg(expected_digit(1), hex4, "hex4 after capture");
  endtask

  task automatic random_play();
    scan_code_e code;
    for (int i = 0; i < RANDOM_KEYS; i++) begin
      rng = xorshift(rng);
      case (rng % 6)
        0:       code = key_up;
        1:       code = key_down;
        2:       code = key_left;
        3:       code = key_right;
        default: code = key_space;
      endcase
      send_key(code);
      check_all();
    end
    $display("random play done, scores red %0d black %0d", m_red_score, m_black_score);
  endtask

  initial begin
    resetn     = 1'b0;
    scan_code  = key_space;
    scan_valid = 1'b0;
    rng        = 32'he8c7_83ee;
    err_board  = 0;
    err_coord  = 0;
    err_player = 0;
    err_seg    = 0;
    err_flag   = 0;
    m_board       = start_position();
    m_turn        = red;
    m_red_score   = '0;
    m_black_score = '0;
    {m_cx, m_cy, m_sx, m_sy} = '0;
    m_state = start_screen;
    m_brk   = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    resetn <= 1'b1;
    after_reset();
    cursor_moves();
    selection_highlight();
    simple_moves();
    scripted_capture();
    random_play();
    $display("errors: board %0d, coord %0d, player %0d, seg %0d, flag %0d",
             err_board, err_coord, err_player, err_seg, err_flag);
    if (err_board + err_coord + err_player + err_seg + err_flag == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

`default_nettype wire

// ==== source/checkers_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module checkers_top (
  input  logic               clk,
  input  logic               resetn,
  input  ui_pkg::scan_code_e scan_code,
  input  logic               scan_valid,
  output board_pkg::board_t  board,
  output board_pkg::player_e turn,
  output board_pkg::coord_t  cursor_x,
  output board_pkg::coord_t  cursor_y,
  output board_pkg::coord_t  sel_x,
  output board_pkg::coord_t  sel_y,
  output logic               show_highlight,
  output ui_pkg::seg_t       hex0,
  output ui_pkg::seg_t       hex1,
  output ui_pkg::seg_t       hex4,
  output ui_pkg::seg_t       hex5
);
  import board_pkg::*;

  logic   go;
  logic   latch_sel;
  logic   apply_move;
  score_t red_score;
  score_t black_score;

  scan_decoder scan_decoder_i (
    .clk        (clk),
    .resetn     (resetn),
    .scan_code  (scan_code),
    .scan_valid (scan_valid),
    .cursor_x   (cursor_x),
    .cursor_y   (cursor_y),
    .go         (go)
  );

  turn_control turn_control_i (
    .clk            (clk),
    .resetn         (resetn),
    .go             (go),
    .latch_sel      (latch_sel),
    .apply_move     (apply_move),
    .show_highlight (show_highlight)
  );

  move_engine move_engine_i (
    .clk         (clk),
    .resetn      (resetn),
    .cursor_x    (cursor_x),
    .cursor_y    (cursor_y),
    .latch_sel   (latch_sel),
    .apply_move  (apply_move),
    .board       (board),
    .turn        (turn),
    .sel_x       (sel_x),
    .sel_y       (sel_y),
    .red_score   (red_score),
    .black_score (black_score)
  );

  score_display score_display_i (
    .red_score   (red_score),
    .black_score (black_score),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex4        (hex4),
    .hex5        (hex5)
  );

endmodule

`default_nettype wire

// ==== source/score_display.sv ====
`timescale 1ns/1ps
`default_nettype none

module score_display (
  input  board_pkg::score_t red_score,
  input  board_pkg::score_t black_score,
  output ui_pkg::seg_t      hex0,
  output ui_pkg::seg_t      hex1,
  output ui_pkg::seg_t      hex4,
  output ui_pkg::seg_t      hex5
);
  import board_pkg::*;
  import ui_pkg::*;

  // Scores stay below 20, so tens is 0 or 1
  function automatic score_t tens_of(input score_t s);
    return (s > score_t'(9)) ? score_t'(1) : score_t'(0);
  endfunction

  function automatic score_t ones_of(input score_t s);
    return (s > score_t'(9)) ? score_t'(s - score_t'(10)) : s;
  endfunction

  // Literals written g..a, lit segment is 0
  function automatic seg_t digit_seg(input score_t d);
    case (d)
      4'd0:    return 7'b100_0000;
      4'd1:    return 7'b111_1001;
      4'd2:    return 7'b010_0100;
      4'd3:    return 7'b011_0000;
      4'd4:    return 7'b001_1001;
      4'd5:    return 7'b001_0010;
      4'd6:    return 7'b000_0010;
      4'd7:    return 7'b111_1000;
      4'd8:    return 7'b000_0000;
      4'd9:    return 7'b001_0000;
      default: return 7'b111_1111;  // Blank
    endcase
  endfunction

  assign hex0 = digit_seg(ones_of(black_score));
  assign hex1 = digit_seg(tens_of(black_score));
  assign hex4 = digit_seg(ones_of(red_score));
  assign hex5 = digit_seg(tens_of(red_score));

endmodule

`default_nettype wire

// ==== source/move_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "checkers_macros.svh"

module move_engine (
  input  logic               clk,
  input  logic               resetn,
  input  board_pkg::coord_t  cursor_x,
  input  board_pkg::coord_t  cursor_y,
  input  logic               latch_sel,
  input  logic               apply_move,
  output board_pkg::board_t  board,
  output board_pkg::player_e turn,
  output board_pkg::coord_t  sel_x,
  output board_pkg::coord_t  sel_y,
  output board_pkg::score_t  red_score,
  output board_pkg::score_t  black_score
);
  import board_pkg::*;

  piece_e src_pc;
  piece_e dst_pc;
  piece_e mid_pc;
  piece_e moved_pc;
  coord_t mid_x;
  coord_t mid_y;
  coord_t dx;
  coord_t dy;
  logic   own_pc;
  logic   opp_mid;
  logic   is_king;
  logic   fwd;
  logic   step;
  logic   jump;
  logic   move_ok;
  board_t board_nxt;

  // Men on the dark squares, x+y even
  function automatic board_t start_board();
    board_t b;
    for (int y = 0; y < `CK_BOARD_DIM; y++) begin
      for (int x = 0; x < `CK_BOARD_DIM; x++) begin
        if ((x + y) % 2 != 0)
          b[y][x] = empty;
        else if (y <= `CK_RED_LAST_ROW)
          b[y][x] = red_man;
        else if (y >= `CK_BLACK_FIRST_ROW)
          b[y][x] = black_man;
        else
          b[y][x] = empty;
      end
    end
    return b;
  endfunction

  assign src_pc = board[sel_y][sel_x];
  assign dst_pc = board[cursor_y][cursor_x];

  // Middle square, only meaningful for a two-step move
  assign mid_x  = coord_t'(({1'b0, sel_x} + {1'b0, cursor_x}) >> 1);
  assign mid_y  = coord_t'(({1'b0, sel_y} + {1'b0, cursor_y}) >> 1);
  assign mid_pc = board[mid_y][mid_x];

  assign dx = (cursor_x > sel_x) ? coord_t'(cursor_x - sel_x) : coord_t'(sel_x - cursor_x);
  assign dy = (cursor_y > sel_y) ? coord_t'(cursor_y - sel_y) : coord_t'(sel_y - cursor_y);

  assign own_pc  = (turn == red) ? (src_pc inside {red_man, red_king})
                                 : (src_pc inside {black_man, black_king});
  assign opp_mid = (turn == red) ? (mid_pc inside {black_man, black_king})
                                 : (mid_pc inside {red_man, red_king});
  assign is_king = src_pc inside {red_king, black_king};
  assign fwd     = (turn == red) ? (cursor_y > sel_y) : (cursor_y < sel_y);  // Red heads up the rows

  assign step    = (dx == coord_t'(1)) && (dy == coord_t'(1));
  assign jump    = (dx == coord_t'(2)) && (dy == coord_t'(2)) && opp_mid;
  assign move_ok = own_pc && (dst_pc == empty) && (is_king || fwd) && (step || jump);

  // Crowning on the far row
  always_comb begin
    if (src_pc == red_man && cursor_y == coord_t'(`CK_BOARD_DIM - 1))
      moved_pc = red_king;
    else if (src_pc == black_man && cursor_y == coord_t'(0))
      moved_pc = black_king;
    else
      moved_pc = src_pc;
  end

  always_comb begin
    board_nxt = board;
    board_nxt[sel_y][sel_x] = empty;
    if (jump)
      board_nxt[mid_y][mid_x] = empty;  // Captured piece
    board_nxt[cursor_y][cursor_x] = moved_pc;
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      board       <= start_board();
      turn        <= red;
      sel_x       <= '0;
      sel_y       <= '0;
      red_score   <= '0;
      black_score <= '0;
    end else begin
      if (latch_sel) begin
        sel_x <= cursor_x;
        sel_y <= cursor_y;
      end
      if (apply_move && move_ok) begin
        board <= board_nxt;
        turn  <= (turn == red) ? black : red;
        if (jump && turn == red)
          red_score <= score_t'(red_score + 1'b1);
        if (jump && turn == black)
          black_score <= score_t'(black_score + 1'b1);
      end
    end
  end

  // Turn only ever advances through a committed move
  a_turn_on_move: assert property (
    @(posedge clk) disable iff (!resetn)
    $changed(turn) |-> $past(apply_move)
  );

endmodule

`default_nettype wire

// ==== source/turn_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module turn_control (
  input  logic clk,
  input  logic resetn,
  input  logic go,
  output logic latch_sel,
  output logic apply_move,
  output logic show_highlight
);
  import ui_pkg::*;

  turn_state_e state;
  turn_state_e state_nxt;
  logic        go_q;  // go delayed one cycle, commands issue from this

  always_comb begin
    state_nxt = state;
    if (go_q) begin
      case (state)
        start_screen: state_nxt = pick_piece;
        pick_piece:   state_nxt = place_piece;
        place_piece:  state_nxt = pick_piece;
        default:      state_nxt = start_screen;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= start_screen;
      go_q  <= 1'b0;
    end else begin
      state <= state_nxt;
      go_q  <= go;
    end
  end

  // Commands sit in the cycle before the state moves on
  assign latch_sel      = go_q && (state == pick_piece);
  assign apply_move     = go_q && (state == place_piece);
  assign show_highlight = (state == place_piece);

  a_cmd_onehot: assert property (
    @(posedge clk) disable iff (!resetn)
    !(latch_sel && apply_move)
  );

endmodule

`default_nettype wire

// ==== source/scan_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module scan_decoder (
  input  logic               clk,
  input  logic               resetn,
  input  ui_pkg::scan_code_e scan_code,
  input  logic               scan_valid,
  output board_pkg::coord_t  cursor_x,
  output board_pkg::coord_t  cursor_y,
  output logic               go
);
  import board_pkg::*;
  import ui_pkg::*;

  logic brk_seen;  // Last accepted code was the F0 prefix

  // Arrow keys arrive as E0 xx, the E0 falls into the default branch.
  // A release E0 F0 xx sets brk_seen on F0 and drops xx
  always_ff @(posedge clk) begin
    if (!resetn) begin
      cursor_x <= '0;
      cursor_y <= '0;
      go       <= 1'b0;
      brk_seen <= 1'b0;
    end else begin
      go <= 1'b0;  // Single cycle pulse
      if (scan_valid) begin
        if (brk_seen) begin
          brk_seen <= 1'b0;  // Key release, ignore code
        end else begin
          case (scan_code)
            key_break: brk_seen <= 1'b1;
            key_left:  cursor_x <= coord_t'(cursor_x - 1'b1);  // Wraps 0 -> 7
            key_right: cursor_x <= coord_t'(cursor_x + 1'b1);
            key_up:    cursor_y <= coord_t'(cursor_y - 1'b1);
            key_down:  cursor_y <= coord_t'(cursor_y + 1'b1);  // Wraps 7 -> 0
            key_space: go <= 1'b1;
            default: ;
          endcase
        end
      end
    end
  end

  // Strobes are spaced, so go must never stretch
  a_go_single: assert property (
    @(posedge clk) disable iff (!resetn)
    go |=> !go
  );

endmodule

`default_nettype wire

// ==== source/ui_pkg.sv ====
`default_nettype none

`include "checkers_macros.svh"

package ui_pkg;

  typedef enum logic [1:0] {
    start_screen,
    pick_piece,
    place_piece
  } turn_state_e;

  typedef enum logic [`CK_SCAN_W-1:0] {
    key_space = `CK_KEY_SPACE,
    key_up    = `CK_KEY_UP,
    key_down  = `CK_KEY_DOWN,
    key_left  = `CK_KEY_LEFT,
    key_right = `CK_KEY_RIGHT,
    key_break = `CK_KEY_BREAK
  } scan_code_e;

  // Active low, bit 0 is segment a
  typedef logic [`CK_SEG_W-1:0] seg_t;

endpackage

`default_nettype wire

// ==== source/board_pkg.sv ====
`default_nettype none

`include "checkers_macros.svh"

package board_pkg;

  // Square contents, 3 bits per square
  typedef enum logic [2:0] {
    empty      = 3'd0,
    black_man  = 3'd1,
    red_man    = 3'd2,
    black_king = 3'd3,
    red_king   = 3'd4
  } piece_e;

  typedef logic [`CK_COORD_W-1:0] coord_t;  // Column or row index

  // Indexed as board[y][x], square (0,0) in the low bits
  typedef piece_e [`CK_BOARD_DIM-1:0][`CK_BOARD_DIM-1:0] board_t;

  typedef logic [`CK_SCORE_W-1:0] score_t;  // Captures so far

  typedef enum logic {
    red   = 1'b0,
    black = 1'b1
  } player_e;

endpackage

`default_nettype wire

// ==== source/checkers_macros.svh ====
`ifndef CHECKERS_MACROS_SVH
`define CHECKERS_MACROS_SVH

// Board geometry
`define CK_BOARD_DIM 8
`define CK_COORD_W 3
`define CK_SCORE_W 4

// Keyboard and display widths
`define CK_SCAN_W 8
`define CK_SEG_W 7

// Set 2 scan codes
`define CK_KEY_SPACE 8'h29
`define CK_KEY_UP 8'h75
`define CK_KEY_DOWN 8'h72
`define CK_KEY_LEFT 8'h6B
`define CK_KEY_RIGHT 8'h74
`define CK_KEY_BREAK 8'hF0

// Start position, red fills rows 0..2 and black rows 5..7
`define CK_RED_LAST_ROW 2
`define CK_BLACK_FIRST_ROW 5

`endif
